//--- hw/memory_game_pkg.sv
`default_nettype none

package memory_game_pkg;

    ////////////////////////////////////////
    // card encoding
    ////////////////////////////////////////

    // 2-bit card state, same codes the renderer decodes
    typedef enum logic [1:0] {
        card_inactive  = 2'b00,  // matched or empty slot
        card_face_up   = 2'b01,  // turned over
        card_face_down = 2'b10   // hidden
    } card_state_e;

    // colour on top, r g b nibbles from msb down
    typedef struct packed {
        logic [11:0] color;
        card_state_e state;
    } card_t;

    ////////////////////////////////////////
    // controller states
    ////////////////////////////////////////

    typedef enum logic [2:0] {
        idle,
        dealing,      // dealer filling the table
        wait_first,
        wait_second,
        reveal,       // compare cycle
        hide          // hold delay, then two table writes
    } ctrl_state_e;

    // deck palette
    localparam logic [11:0] color_red     = 12'hf_0_0;
    localparam logic [11:0] color_green   = 12'h0_f_0;
    localparam logic [11:0] color_blue    = 12'h0_0_f;
    localparam logic [11:0] color_cyan    = 12'h0_f_f;
    localparam logic [11:0] color_magenta = 12'hf_0_f;
    localparam logic [11:0] color_yellow  = 12'hf_f_0;
    localparam logic [11:0] color_black   = 12'h0_0_0;  // empty slot after reset

endpackage

`default_nettype wire

//--- hw/deal_colors.sv
`timescale 1ns/1ns
`default_nettype none

module deal_colors (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   enable,     // level, high through dealing
    output logic                   deal_we,
    output logic [3:0]             deal_addr,
    output memory_game_pkg::card_t deal_card,
    output logic                   deal_done   // one cycle after slot 15 is written
);

    logic [3:0]  addr;        // slot being written this cycle
    logic [11:0] deck_color;

    always_ff @(posedge clk) begin
        if (rst) begin
            addr      <= 4'd0;
            deal_done <= 1'b0;
        end else begin
            deal_done <= enable && !deal_done && (addr == 4'hf);
            if (enable && !deal_done)
                addr <= addr + 4'd1;  // wraps to 0 after the last slot
            else
                addr <= 4'd0;         // parked until next deal
        end
    end

    // fixed deck, no shuffle
    always_comb begin
        case (addr)
            4'h0:    deck_color = memory_game_pkg::color_red;
            4'h1:    deck_color = memory_game_pkg::color_red;
            4'h2:    deck_color = memory_game_pkg::color_green;
            4'h3:    deck_color = memory_game_pkg::color_blue;
            4'h4:    deck_color = memory_game_pkg::color_cyan;
            4'h5:    deck_color = memory_game_pkg::color_magenta;
            4'h6:    deck_color = memory_game_pkg::color_yellow;
            4'h7:    deck_color = memory_game_pkg::color_red;    // odd one, no partner
            4'h8:    deck_color = memory_game_pkg::color_green;
            4'h9:    deck_color = memory_game_pkg::color_blue;
            4'ha:    deck_color = memory_game_pkg::color_cyan;
            4'hb:    deck_color = memory_game_pkg::color_magenta;
            4'hc:    deck_color = memory_game_pkg::color_yellow;
            4'hd:    deck_color = memory_game_pkg::color_green;  // odd one, no partner
            4'he:    deck_color = memory_game_pkg::color_blue;
            4'hf:    deck_color = memory_game_pkg::color_blue;
            default: deck_color = memory_game_pkg::color_black;
        endcase
    end

    assign deal_we         = enable && !deal_done;  // quiet in the done cycle
    assign deal_addr       = addr;
    assign deal_card.color = deck_color;
    assign deal_card.state = memory_game_pkg::card_face_down;  // every card dealt hidden

endmodule

`default_nettype wire

//--- hw/card_table.sv
`timescale 1ns/1ns
`default_nettype none

module card_table (
    input  logic                   clk,
    input  logic                   rst,
    // dealer write port
    input  logic                   deal_we,
    input  logic [3:0]             deal_addr,
    input  memory_game_pkg::card_t deal_card,
    // controller write port
    input  logic                   ctrl_we,
    input  logic [3:0]             ctrl_addr,
    input  memory_game_pkg::card_t ctrl_card,
    // read ports, all combinational
    input  logic [3:0]             pick_index,
    output memory_game_pkg::card_t pick_card,
    input  logic [3:0]             first_index,
    output memory_game_pkg::card_t first_card,
    input  logic [3:0]             view_index,
    output memory_game_pkg::card_t view_card
);

    memory_game_pkg::card_t cards [0:15];

    ////////////////////////////////////////
    // write side
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 16; i++) begin
                cards[i].color <= memory_game_pkg::color_black;
                cards[i].state <= memory_game_pkg::card_inactive;
            end
        end else if (deal_we) begin
            cards[deal_addr] <= deal_card;   // dealer first
        end else if (ctrl_we) begin
            cards[ctrl_addr] <= ctrl_card;
        end
    end

    ////////////////////////////////////////
    // read side
    ////////////////////////////////////////

    assign pick_card  = cards[pick_index];   // pick validation
    assign first_card = cards[first_index];  // remembered first card
    assign view_card  = cards[view_index];   // renderer view

endmodule

`default_nettype wire

//--- hw/game_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module game_ctrl #(
    parameter int hide_cycles = 4,  // face-up hold after a miss
    parameter int win_pairs   = 7
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  logic                   pick,
    input  logic [3:0]             pick_index,
    input  memory_game_pkg::card_t pick_card,
    input  memory_game_pkg::card_t first_card,
    output logic [3:0]             first_index,
    output logic                   deal_enable,
    input  logic                   deal_done,
    output logic                   ctrl_we,
    output logic [3:0]             ctrl_addr,
    output memory_game_pkg::card_t ctrl_card,
    output logic                   ready,
    output logic                   match,
    output logic                   miss,
    output logic                   game_over,
    output logic [3:0]             score
);

    localparam int cnt_w = $clog2(hide_cycles + 2);

    memory_game_pkg::ctrl_state_e state;

    logic [3:0]       second_idx;
    logic [11:0]      second_color;  // no read port for the second card, keep its colour
    logic [cnt_w-1:0] hide_cnt;
    logic             write_second;  // 0 first card, 1 second card
    logic             clear_pair;    // matched pair goes inactive
    logic             pick_ok;
    logic             colors_equal;

    assign pick_ok      = pick && (pick_card.state == memory_game_pkg::card_face_down);
    assign colors_equal = (first_card.color == second_color);

    assign ready = (state == memory_game_pkg::wait_first) ||
                   (state == memory_game_pkg::wait_second);
    assign deal_enable = (state == memory_game_pkg::dealing);
    assign match       = (state == memory_game_pkg::reveal) && colors_equal;
    assign miss        = (state == memory_game_pkg::reveal) && !colors_equal;

    ////////////////////////////////////////
    // state machine and score
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= memory_game_pkg::idle;
            score        <= 4'd0;
            game_over    <= 1'b0;
            hide_cnt     <= '0;
            write_second <= 1'b0;
            clear_pair   <= 1'b0;
        end else if (start) begin
            // restart from anywhere
            state        <= memory_game_pkg::dealing;
            score        <= 4'd0;
            game_over    <= 1'b0;
            write_second <= 1'b0;
        end else begin
            case (state)
                memory_game_pkg::dealing: begin
                    if (deal_done)
                        state <= memory_game_pkg::wait_first;
                end
                memory_game_pkg::wait_first: begin
                    if (pick_ok)
                        state <= memory_game_pkg::wait_second;
                end
                memory_game_pkg::wait_second: begin
                    if (pick_ok)
                        state <= memory_game_pkg::reveal;  // ready drops here
                end
                memory_game_pkg::reveal: begin
                    clear_pair <= colors_equal;
                    score      <= score + {3'b000, colors_equal};
                    hide_cnt   <= colors_equal ? '0 : cnt_w'(hide_cycles);  // match skips hold
                    state      <= memory_game_pkg::hide;
                end
                memory_game_pkg::hide: begin
                    if (hide_cnt != '0) begin
                        hide_cnt <= hide_cnt - 1'b1;
                    end else if (!write_second) begin
                        write_second <= 1'b1;          // first card written this edge
                    end else begin
                        write_second <= 1'b0;
                        if (score == 4'(win_pairs)) begin
                            game_over <= 1'b1;
                            state     <= memory_game_pkg::idle;
                        end else begin
                            state <= memory_game_pkg::wait_first;
                        end
                    end
                end
                default: ;  // idle waits for start
            endcase
        end
    end

    // pick indexes and colour, payload only
    always_ff @(posedge clk) begin
        if (state == memory_game_pkg::wait_first && pick_ok)
            first_index <= pick_index;
        if (state == memory_game_pkg::wait_second && pick_ok) begin
            second_idx   <= pick_index;
            second_color <= pick_card.color;
        end
    end

    ////////////////////////////////////////
    // table writes, one card per cycle
    ////////////////////////////////////////

    always_comb begin
        ctrl_we         = 1'b0;
        ctrl_addr       = pick_index;
        ctrl_card.color = pick_card.color;
        ctrl_card.state = memory_game_pkg::card_face_up;  // turn picked card over
        case (state)
            memory_game_pkg::wait_first,
            memory_game_pkg::wait_second: ctrl_we = pick_ok;
            memory_game_pkg::hide: begin
                if (hide_cnt == '0) begin
                    ctrl_we         = 1'b1;
                    ctrl_addr       = write_second ? second_idx : first_index;
                    ctrl_card.color = write_second ? second_color : first_card.color;
                    ctrl_card.state = clear_pair ? memory_game_pkg::card_inactive
                                                 : memory_game_pkg::card_face_down;
                end
            end
            default: ;
        endcase
        if (start)
            ctrl_we = 1'b0;  // dealer rewrites everything anyway
    end

endmodule

`default_nettype wire

//--- hw/memory_game_top.sv
`timescale 1ns/1ns
`default_nettype none

module memory_game_top #(
    parameter int hide_cycles = 4,
    parameter int win_pairs   = 7   // disjoint equal pairs in the deck
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,       // strobe
    input  logic                   pick,        // strobe
    input  logic [3:0]             pick_index,
    input  logic [3:0]             view_index,
    output memory_game_pkg::card_t view_card,   // combinational, always valid
    output logic                   ready,
    output logic                   match,       // pulse
    output logic                   miss,        // pulse
    output logic [3:0]             score,
    output logic                   game_over
);

    // dealer to table
    logic                   deal_enable;
    logic                   deal_done;
    logic                   deal_we;
    logic [3:0]             deal_addr;
    memory_game_pkg::card_t deal_card;

    // controller to and from table
    logic                   ctrl_we;
    logic [3:0]             ctrl_addr;
    memory_game_pkg::card_t ctrl_card;
    logic [3:0]             first_index;
    memory_game_pkg::card_t first_card;
    memory_game_pkg::card_t pick_card;

    deal_colors deal_colors_inst (
        .clk       (clk),
        .rst       (rst),
        .enable    (deal_enable),
        .deal_we   (deal_we),
        .deal_addr (deal_addr),
        .deal_card (deal_card),
        .deal_done (deal_done)
    );

    card_table card_table_inst (
        .clk         (clk),
        .rst         (rst),
        .deal_we     (deal_we),
        .deal_addr   (deal_addr),
        .deal_card   (deal_card),
        .ctrl_we     (ctrl_we),
        .ctrl_addr   (ctrl_addr),
        .ctrl_card   (ctrl_card),
        .pick_index  (pick_index),
        .pick_card   (pick_card),
        .first_index (first_index),
        .first_card  (first_card),
        .view_index  (view_index),
        .view_card   (view_card)
    );

    game_ctrl #(
        .hide_cycles (hide_cycles),
        .win_pairs   (win_pairs)
    ) game_ctrl_inst (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .pick        (pick),
        .pick_index  (pick_index),
        .pick_card   (pick_card),
        .first_card  (first_card),
        .first_index (first_index),
        .deal_enable (deal_enable),
        .deal_done   (deal_done),
        .ctrl_we     (ctrl_we),
        .ctrl_addr   (ctrl_addr),
        .ctrl_card   (ctrl_card),
        .ready       (ready),
        .match       (match),
        .miss        (miss),
        .game_over   (game_over),
        .score       (score)
    );

endmodule

`default_nettype wire

//--- tests/memory_game_chk.sv
`timescale 1ns/1ns
`default_nettype none

module memory_game_chk (
    input logic                         clk,
    input logic                         rst,
    input logic                         match,
    input logic                         miss,
    input logic                         ready,
    input logic                         game_over,
    input logic                         ctrl_we,
    input logic                         deal_enable,
    input logic [3:0]                   score,
    input memory_game_pkg::ctrl_state_e state
);

    ////////////////////////////////////////
    // pulse and level rules
    ////////////////////////////////////////

    pulse_excl: assert property (@(posedge clk) disable iff (rst) !(match && miss))
        else $error("match and miss high in the same cycle");

    over_not_ready: assert property (@(posedge clk) disable iff (rst) game_over |-> !ready)
        else $error("ready high while game_over is set");

    // dealer and controller never share the table
    one_writer: assert property (@(posedge clk) disable iff (rst) !(ctrl_we && deal_enable))
        else $error("controller write during dealing");

    // score only steps after a match cycle
    score_step: assert property (@(posedge clk) disable iff (rst)
        (score > $past(score)) |-> $past(match))
        else $error("score rose without a match pulse");

    // finished game parks the controller until the next start
    over_idle: assert property (@(posedge clk) disable iff (rst)
        game_over |-> (state == memory_game_pkg::idle))
        else $error("game_over set outside idle");

endmodule

bind game_ctrl memory_game_chk memory_game_chk_inst (
    .clk         (clk),
    .rst         (rst),
    .match       (match),
    .miss        (miss),
    .ready       (ready),
    .game_over   (game_over),
    .ctrl_we     (ctrl_we),
    .deal_enable (deal_enable),
    .score       (score),
    .state       (state)
);

`default_nettype wire

//--- tests/memory_game_tb.sv
`timescale 1ns/1ns
`default_nettype none

module memory_game_tb;

    localparam int win_pairs   = 7;
    localparam int deal_limit  = 40;  // cycles for a full deal
    localparam int pair_limit  = 40;  // reveal plus hold plus writes
    localparam int pulse_limit = 8;

    // deck order as the dealer lays it out
    localparam logic [11:0] deck [0:15] = '{
        12'hf00, 12'hf00, 12'h0f0, 12'h00f, 12'h0ff, 12'hf0f, 12'hff0, 12'hf00,
        12'h0f0, 12'h00f, 12'h0ff, 12'hf0f, 12'hff0, 12'h0f0, 12'h00f, 12'h00f
    };
    localparam int pair_a [0:6] = '{0, 2, 3, 4, 5, 6, 14};
    localparam int pair_b [0:6] = '{1, 8, 9, 10, 11, 12, 15};

    logic                   clk;
    logic                   rst;
    logic                   start;
    logic                   pick;
    logic [3:0]             pick_index;
    logic [3:0]             view_index;
    memory_game_pkg::card_t view_card;
    logic                   ready;
    logic                   match;
    logic                   miss;
    logic [3:0]             score;
    logic                   game_over;

    // reference model of table and score
    logic [11:0]                  model_color [0:15];
    memory_game_pkg::card_state_e model_state [0:15];
    int                           model_score;

    integer seed;
    int     error_count;
    int     test_errors;   // error count when the current test began
    int     test_count;
    int     failed_tests;
    int     match_count;
    int     miss_count;

    memory_game_top memory_game_top_inst (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .pick       (pick),
        .pick_index (pick_index),
        .view_index (view_index),
        .view_card  (view_card),
        .ready      (ready),
        .match      (match),
        .miss       (miss),
        .score      (score),
        .game_over  (game_over)
    );

    always #4 clk = ~clk;  // 8 ns period

    // pulse tally sampled mid cycle
    always @(negedge clk) begin
        if (!rst && match)
            match_count++;
        if (!rst && miss)
            miss_count++;
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    task automatic compare_value(input logic [31:0] got, input logic [31:0] exp,
                                 input string what);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic press_pick(input int idx);
        @(negedge clk);
        pick       = 1'b1;
        pick_index = 4'(idx);
        @(negedge clk);
        pick       = 1'b0;  // one-cycle strobe
    endtask

    task automatic wait_ready_or_over(input string what);
        int cycles;
        cycles = 0;
        while (!ready && !game_over && cycles < pair_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!ready && !game_over) begin
            $display("timeout: neither ready nor game_over came back after %s", what);
            error_count++;
        end
    endtask

    task automatic deal_fresh();
        int cycles;
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        model_score = 0;
        for (int i = 0; i < 16; i++) begin
            model_color[i] = deck[i];
            model_state[i] = memory_game_pkg::card_face_down;
        end
        cycles = 0;
        while (!ready && cycles < deal_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!ready) begin
            $display("timeout: ready did not rise within %0d cycles of start", deal_limit);
            error_count++;
        end
    endtask

    task automatic compare_table(input string what);
        memory_game_pkg::card_t exp;
        for (int i = 0; i < 16; i++) begin
            @(negedge clk);
            view_index = 4'(i);
            #1;                           // view port is combinational
            exp.color = model_color[i];
            exp.state = model_state[i];
            compare_value(view_card, exp, $sformatf("%s, card %0d", what, i));
        end
    endtask

    task automatic compare_status(input string what);
        compare_value(score, model_score, {what, ", score"});
        compare_value(game_over, model_score == win_pairs, {what, ", game_over"});
        compare_value(ready, model_score != win_pairs, {what, ", ready"});
    endtask

    function automatic int face_down_count();
        int n;
        n = 0;
        for (int i = 0; i < 16; i++)
            if (model_state[i] == memory_game_pkg::card_face_down)
                n++;
        return n;
    endfunction

    task automatic draw_face_down(input int avoid, output int idx);
        logic [31:0] r;
        idx = -1;
        for (int tries = 0; tries < 256 && idx < 0; tries++) begin
            r = $random(seed);
            if (model_state[r[3:0]] == memory_game_pkg::card_face_down && r[3:0] != avoid)
                idx = int'(r[3:0]);
        end
        for (int i = 0; i < 16 && idx < 0; i++)  // fallback scan
            if (model_state[i] == memory_game_pkg::card_face_down && i != avoid)
                idx = i;
    endtask

    task automatic play_pair(input int a, input int b);
        logic expect_match;
        int   cycles;
        press_pick(a);
        model_state[a] = memory_game_pkg::card_face_up;
        press_pick(b);
        model_state[b] = memory_game_pkg::card_face_up;
        expect_match = (model_color[a] == model_color[b]);
        cycles = 0;
        while (!match && !miss && cycles < pulse_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!match && !miss) begin
            $display("timeout: no match or miss pulse after picks %0d and %0d", a, b);
            error_count++;
        end else begin
            compare_value(match, expect_match, $sformatf("match pulse, pair %0d/%0d", a, b));
            compare_value(miss, !expect_match, $sformatf("miss pulse, pair %0d/%0d", a, b));
        end
        if (expect_match) begin
            model_state[a] = memory_game_pkg::card_inactive;
            model_state[b] = memory_game_pkg::card_inactive;
            model_score++;
        end else begin
            model_state[a] = memory_game_pkg::card_face_down;  // turned back after hold
            model_state[b] = memory_game_pkg::card_face_down;
        end
        wait_ready_or_over($sformatf("pair %0d/%0d", a, b));
        compare_status($sformatf("pair %0d/%0d", a, b));
    endtask

    task automatic close_test(input string name);
        test_count++;
        if (error_count == test_errors) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: %0d errors", name, error_count - test_errors);
        end
        test_errors = error_count;
    endtask

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////

    initial begin
        int a;
        int b;
        int m0;
        int x0;
        clk          = 1'b0;
        rst          = 1'b1;
        start        = 1'b0;
        pick         = 1'b0;
        pick_index   = 4'd0;
        view_index   = 4'd0;
        seed         = 39977;
        error_count  = 0;
        test_errors  = 0;
        test_count   = 0;
        failed_tests = 0;
        match_count  = 0;
        miss_count   = 0;
        model_score  = 0;
        for (int i = 0; i < 16; i++) begin
            model_color[i] = 12'h000;
            model_state[i] = memory_game_pkg::card_inactive;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // empty table straight out of reset
        compare_table("reset");
        compare_value(ready, 1'b0, "reset, ready");
        compare_value(game_over, 1'b0, "reset, game_over");
        compare_value(score, 4'd0, "reset, score");
        close_test("reset");

        deal_fresh();
        compare_status("deal");
        compare_table("deal");
        close_test("deal");

        // random pairs until the game ends or cards run out
        for (int n = 0; n < 10 && model_score < win_pairs && face_down_count() >= 2; n++) begin
            draw_face_down(-1, a);
            draw_face_down(a, b);
            play_pair(a, b);
            compare_table($sformatf("random pair %0d", n));
        end
        close_test("random picks");

        // picks that must be dropped
        deal_fresh();
        m0 = match_count;
        x0 = miss_count;
        press_pick(0);
        model_state[0] = memory_game_pkg::card_face_up;
        press_pick(1);
        model_state[1] = memory_game_pkg::card_face_up;
        compare_value(ready, 1'b0, "ready after second pick");
        press_pick(4);                         // dropped while ready is low
        wait_ready_or_over("pair 0/1");
        model_state[0] = memory_game_pkg::card_inactive;
        model_state[1] = memory_game_pkg::card_inactive;
        model_score    = 1;
        compare_status("pair 0/1");
        compare_table("pair 0/1");
        press_pick(0);                         // inactive
        compare_table("inactive first pick");
        press_pick(2);
        model_state[2] = memory_game_pkg::card_face_up;
        press_pick(2);                         // same card again
        press_pick(1);                         // inactive as second
        compare_value(ready, 1'b1, "ready after dropped second picks");
        compare_table("dropped second picks");
        press_pick(5);                         // green against magenta
        model_state[5] = memory_game_pkg::card_face_up;
        wait_ready_or_over("pair 2/5");
        model_state[2] = memory_game_pkg::card_face_down;
        model_state[5] = memory_game_pkg::card_face_down;
        compare_status("pair 2/5");
        compare_table("pair 2/5");
        compare_value(match_count - m0, 1, "match pulses in dropped-pick test");
        compare_value(miss_count - x0, 1, "miss pulses in dropped-pick test");
        close_test("ignored picks");

        // clear the seven disjoint pairs
        deal_fresh();
        for (int p = 0; p < 7; p++)
            play_pair(pair_a[p], pair_b[p]);
        compare_value(game_over, 1'b1, "win, game_over");
        compare_value(score, 4'd7, "win, score");
        compare_table("win");
        deal_fresh();
        compare_status("redeal");
        compare_table("redeal");
        close_test("win");

        $display("tests %0d, failed %0d, errors %0d", test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- memory_game.f
hw/memory_game_pkg.sv
hw/deal_colors.sv
hw/card_table.sv
hw/game_ctrl.sv
hw/memory_game_top.sv
tests/memory_game_chk.sv
tests/memory_game_tb.sv

//--- Makefile
# Verilator build and run for the memory game testbench

VERILATOR ?= verilator
TOP       ?= memory_game_tb
FILELIST  ?= memory_game.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= TESTS PASSED
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard hw/*.sv tests/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
